// File: sim.f
design/uart_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/frame_sender.sv
design/frame_assembler.sv
design/uart_string_top.sv
verification/tb_uart_string.sv

// File: Makefile
# Verilator build and run for the uart string transceiver testbench

SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_uart_string
FILELIST = sim.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: verification/tb_uart_string.sv
/*
 * testbench for the uart string transceiver
 * drives the serial input bit by bit, samples the serial output at mid-bit
 * and checks transmit framing, receive framing, aborts and loopback
 */
`default_nettype none

module tb_uart_string;
	timeunit 1ns;
	timeprecision 1ps;
	import uart_pkg::*;

	localparam int bit_clks  = 25;
	localparam int idle_clks = 2_000;
	localparam int max_bytes = 32;

	// ascii '&', two of them open and close a frame
	localparam logic [7:0] mark_byte = 8'h26;

	logic         sys_clk;
	logic         sys_rst_n;
	uart_string_t tx_string;
	logic         tx_req;
	logic         tx_busy;
	logic         tx_done;
	uart_string_t rx_string;
	logic         rx_done;
	logic         rx_error;
	logic         uart_tx_port;
	logic         drv_line;
	logic         loop_en;
	logic         rx_line;
	int           seed = 35;
	int           rx_done_cnt = 0;
	int           rx_error_cnt = 0;

	always #20 sys_clk = ~sys_clk;

	// serial input comes from the driver, or from the serial output in loopback
	assign rx_line = loop_en ? uart_tx_port : drv_line;

	uart_string_top #(
		.clk_freq          (25_000_000),
		.baud_rate         (1_000_000),
		.idle_timeout_clks (idle_clks)
	) u_uart_string_top (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_done      (rx_done),
		.rx_error     (rx_error),
		.uart_rx_port (rx_line),
		.uart_tx_port (uart_tx_port)
	);

	// pulses can fire while a byte is still being driven
	always @(posedge sys_clk) begin
		if (rx_done)
			rx_done_cnt <= rx_done_cnt + 1;
		if (rx_error)
			rx_error_cnt <= rx_error_cnt + 1;
	end

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			report_failure($sformatf("mismatch %s: expected %b, actual %b",
				name, expected, actual));
	endtask

	task automatic check_byte(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (actual !== expected)
			report_failure($sformatf("mismatch %s: expected %h, actual %h",
				name, expected, actual));
	endtask

	// only the first len bytes carry content
	task automatic check_string(input string name, input uart_string_t expected,
		input uart_string_t actual);
		int   i;
		logic ok;
		ok = (actual.len === expected.len);
		for (i = 0; i < max_bytes; i++) begin
			if (i < expected.len && actual.data[i*8 +: 8] !== expected.data[i*8 +: 8])
				ok = 1'b0;
		end
		if (!ok)
			report_failure($sformatf(
				"mismatch %s: expected len %0d data %h, actual len %0d data %h",
				name, expected.len, expected.data, actual.len, actual.data));
	endtask

	function automatic logic [7:0] rand_byte();
		logic [7:0] b;
		b = 8'($random(seed));
		// content never carries the framing byte
		if (b == mark_byte)
			b = 8'h2a;
		return b;
	endfunction

	function automatic uart_string_t rand_string(input int n);
		uart_string_t s;
		int           i;
		s = '0;
		s.len = len_w'(n);
		for (i = 0; i < n; i++)
			s.data[i*8 +: 8] = rand_byte();
		return s;
	endfunction

	// start, 8 data bits lsb first, stop
	task automatic send_byte(input logic [7:0] b);
		int i;
		drv_line = 1'b0;
		repeat (bit_clks) @(negedge sys_clk);
		for (i = 0; i < 8; i++) begin
			drv_line = b[i];
			repeat (bit_clks) @(negedge sys_clk);
		end
		drv_line = 1'b1;
		repeat (bit_clks) @(negedge sys_clk);
	endtask

	task automatic capture_byte(input string name, output logic [7:0] b);
		int n;
		int i;
		n = 0;
		while (uart_tx_port !== 1'b0) begin
			if (n == 1_000)
				report_failure({"timeout waiting for a start bit on uart_tx_port in ", name});
			@(negedge sys_clk);
			n++;
		end
		// half a bit on lands in the middle of the start bit
		repeat (bit_clks / 2) @(negedge sys_clk);
		if (uart_tx_port !== 1'b0)
			report_failure({"start bit on uart_tx_port did not hold low in ", name});
		for (i = 0; i < 8; i++) begin
			repeat (bit_clks) @(negedge sys_clk);
			b[i] = uart_tx_port;
		end
		repeat (bit_clks) @(negedge sys_clk);
		if (uart_tx_port !== 1'b1)
			report_failure({"stop bit on uart_tx_port was low in ", name});
	endtask

	task automatic start_send(input string name, input uart_string_t str);
		tx_string = str;
		tx_req    = 1'b1;
		@(negedge sys_clk);
		tx_req = 1'b0;
		check_bit({name, " tx_busy after request"}, 1'b1, tx_busy);
	endtask

	// busy must hold until tx_done, an extra request on the way is ignored
	task automatic track_busy(input string name, input int len, input logic extra_req);
		int n;
		n = 0;
		while (tx_done !== 1'b1) begin
			if (n == (len + 4) * 10 * bit_clks + 200)
				report_failure({"timeout waiting for tx_done in ", name});
			check_bit({name, " tx_busy during send"}, 1'b1, tx_busy);
			if (extra_req && n == 200)
				tx_req = 1'b1;
			else
				tx_req = 1'b0;
			@(negedge sys_clk);
			n++;
		end
		check_bit({name, " tx_busy at tx_done"}, 1'b0, tx_busy);
	endtask

	task automatic wait_rx_event(input string name, input int done_base, input int err_base,
		input int limit);
		int n;
		n = 0;
		while (rx_done_cnt == done_base && rx_error_cnt == err_base) begin
			if (n == limit)
				report_failure({"timeout waiting for rx_done or rx_error in ", name});
			@(negedge sys_clk);
			n++;
		end
	endtask

	task automatic expect_good(input string name, input uart_string_t str,
		input int done_base, input int err_base);
		wait_rx_event(name, done_base, err_base, 200);
		check_bit({name, " rx_error seen"}, 1'b0, rx_error_cnt != err_base);
		check_bit({name, " one rx_done"}, 1'b1, rx_done_cnt == done_base + 1);
		check_string(name, str, rx_string);
	endtask

	task automatic test_reset();
		check_bit("reset uart_tx_port", 1'b1, uart_tx_port);
		check_bit("reset tx_busy", 1'b0, tx_busy);
		check_bit("reset tx_done", 1'b0, tx_done);
		check_bit("reset rx_done", 1'b0, rx_done);
		check_bit("reset rx_error", 1'b0, rx_error);
	endtask

	task automatic test_tx(input string name, input uart_string_t str);
		logic [7:0] got [$];
		logic [7:0] b;
		int         i;
		start_send(name, str);
		fork
			begin
				for (i = 0; i < str.len + 4; i++) begin
					capture_byte(name, b);
					got.push_back(b);
				end
			end
			track_busy(name, str.len, 1'b1);
		join
		check_byte({name, " head 0"}, mark_byte, got[0]);
		check_byte({name, " head 1"}, mark_byte, got[1]);
		for (i = 0; i < str.len; i++)
			check_byte($sformatf("%s byte %0d", name, i), str.data[i*8 +: 8], got[i+2]);
		check_byte({name, " tail 0"}, mark_byte, got[str.len+2]);
		check_byte({name, " tail 1"}, mark_byte, got[str.len+3]);
		// two byte times of quiet line, so the extra request sent nothing
		for (i = 0; i < 20 * bit_clks; i++) begin
			check_bit({name, " line idle after send"}, 1'b1, uart_tx_port);
			@(negedge sys_clk);
		end
	endtask

	task automatic test_rx(input string name, input uart_string_t str);
		int done_base;
		int err_base;
		int i;
		done_base = rx_done_cnt;
		err_base  = rx_error_cnt;
		send_byte(mark_byte);
		send_byte(mark_byte);
		for (i = 0; i < str.len; i++)
			send_byte(str.data[i*8 +: 8]);
		send_byte(mark_byte);
		send_byte(mark_byte);
		expect_good(name, str, done_base, err_base);
	endtask

	task automatic test_noise();
		int done_base;
		int err_base;
		done_base = rx_done_cnt;
		err_base  = rx_error_cnt;
		send_byte(8'h55);
		send_byte(8'h00);
		send_byte(mark_byte);
		send_byte(8'h78);
		check_bit("noise rx_done seen", 1'b0, rx_done_cnt != done_base);
		check_bit("noise rx_error seen", 1'b0, rx_error_cnt != err_base);
		test_rx("rx after noise", rand_string(7));
	endtask

	// open a frame with n content bytes and never close it
	task automatic test_abort(input string name, input int n, input int quiet,
		input int limit);
		uart_string_t prev;
		int           done_base;
		int           err_base;
		int           i;
		prev      = rx_string;
		done_base = rx_done_cnt;
		err_base  = rx_error_cnt;
		send_byte(mark_byte);
		send_byte(mark_byte);
		for (i = 0; i < n; i++)
			send_byte(rand_byte());
		// the open frame must survive this long before it is dropped
		for (i = 0; i < quiet; i++) begin
			check_bit({name, " early rx_error"}, 1'b0, rx_error_cnt != err_base);
			@(negedge sys_clk);
		end
		wait_rx_event(name, done_base, err_base, limit);
		check_bit({name, " rx_error seen"}, 1'b1, rx_error_cnt == err_base + 1);
		check_bit({name, " rx_done seen"}, 1'b0, rx_done_cnt != done_base);
		check_string({name, " rx_string kept"}, prev, rx_string);
	endtask

	task automatic test_loopback(input string name, input uart_string_t str);
		int done_base;
		int err_base;
		loop_en   = 1'b1;
		done_base = rx_done_cnt;
		err_base  = rx_error_cnt;
		start_send(name, str);
		track_busy(name, str.len, 1'b0);
		expect_good(name, str, done_base, err_base);
		loop_en = 1'b0;
	endtask

	initial begin
		uart_string_t s;
		sys_clk   = 1'b0;
		sys_rst_n = 1'b0;
		tx_string = '0;
		tx_req    = 1'b0;
		drv_line  = 1'b1;
		loop_en   = 1'b0;
		repeat (4) @(negedge sys_clk);
		sys_rst_n = 1'b1;
		@(negedge sys_clk);
		test_reset();

		s = '0;
		s.len = len_w'(5);
		s.data[39:0] = 40'h6f6c6c6568;
		test_tx("tx five bytes", s);
		test_tx("tx full random", rand_string(max_bytes));

		test_rx("rx random", rand_string(10));
		test_rx("rx empty", rand_string(0));
		s = rand_string(8);
		// lone mark inside content
		s.data[3*8 +: 8] = mark_byte;
		test_rx("rx single mark", s);
		test_rx("rx full", rand_string(max_bytes));

		test_noise();
		test_abort("idle timeout", 3, idle_clks - 50, 200);
		test_abort("overflow", max_bytes + 1, 0, 200);
		test_loopback("loopback", rand_string(12));

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

// File: design/uart_string_top.sv
/*
 * uart string transceiver
 * frame sender and byte transmitter on the tx side,
 * byte receiver and frame assembler on the rx side
 */
`default_nettype none

module uart_string_top #(
	parameter int clk_freq          = 50_000_000,
	parameter int baud_rate         = 115_200,
	parameter int idle_timeout_clks = 50_000
) (
	input  wire                         sys_clk,
	input  wire                         sys_rst_n,
	input  wire uart_pkg::uart_string_t tx_string,
	input  wire                         tx_req,
	output wire                         tx_busy,
	output wire                         tx_done,
	output wire uart_pkg::uart_string_t rx_string,
	output wire                         rx_done,
	output wire                         rx_error,
	input  wire                         uart_rx_port,
	output wire                         uart_tx_port
);

	logic [7:0] tx_byte_data;
	logic       tx_byte_req;
	logic       tx_byte_done;
	logic [7:0] rx_byte_data;
	logic       rx_byte_vld;

	// transmit path
	frame_sender u_frame_sender (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_string (tx_string),
		.tx_req    (tx_req),
		.byte_done (tx_byte_done),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.byte_data (tx_byte_data),
		.byte_req  (tx_byte_req)
	);

	uart_tx #(
		.clk_freq  (clk_freq),
		.baud_rate (baud_rate)
	) u_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_data (tx_byte_data),
		.byte_req  (tx_byte_req),
		.tx        (uart_tx_port),
		.byte_done (tx_byte_done)
	);

	// receive path
	uart_rx #(
		.clk_freq  (clk_freq),
		.baud_rate (baud_rate)
	) u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (uart_rx_port),
		.byte_data (rx_byte_data),
		.byte_vld  (rx_byte_vld)
	);

	frame_assembler #(
		.idle_timeout_clks (idle_timeout_clks)
	) u_frame_assembler (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_data (rx_byte_data),
		.byte_vld  (rx_byte_vld),
		.rx_string (rx_string),
		.rx_done   (rx_done),
		.rx_error  (rx_error)
	);

endmodule

`default_nettype wire

// File: design/frame_assembler.sv
/*
 * framed string assembler
 * hunts for "&&", collects content up to the closing "&&"
 * and publishes it; idle timeout or overflow drops the frame
 */
`default_nettype none

module frame_assembler #(
	parameter int idle_timeout_clks = 50_000
) (
	input  wire                    sys_clk,
	input  wire                    sys_rst_n,
	input  wire  [7:0]             byte_data,
	input  wire                    byte_vld,
	output uart_pkg::uart_string_t rx_string,
	output logic                   rx_done,
	output logic                   rx_error
);
	import uart_pkg::*;

	localparam int idle_w = $clog2(idle_timeout_clks + 1);

	asm_state_t                 state;
	logic [idle_w-1:0]          idle_cnt;
	logic [str_max_bytes*8-1:0] fill_data;
	logic [len_w-1:0]           fill_len;
	logic                       is_mark;
	logic                       timeout;
	logic                       store_one;
	logic                       store_two;
	logic                       overflow;
	logic                       frame_open;

	assign is_mark = (byte_data == frame_mark);

	assign timeout = (state != asm_hunt) &&
		(idle_cnt == idle_w'(idle_timeout_clks));

	// plain content byte
	assign store_one = byte_vld && (state == asm_body) && !is_mark;

	// held single mark plus the byte after it
	assign store_two = byte_vld && (state == asm_pend_mark) && !is_mark;

	assign overflow = (store_one && fill_len >= len_w'(str_max_bytes)) ||
		(store_two && fill_len >= len_w'(str_max_bytes - 1));

	// second opening mark
	assign frame_open = byte_vld && (state == asm_mark1) && is_mark;

	// counts clocks since the last byte while inside a frame
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			idle_cnt <= '0;
		else if (state == asm_hunt || byte_vld || timeout)
			idle_cnt <= '0;
		else
			idle_cnt <= idle_cnt + 1'b1;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= asm_hunt;
			fill_len  <= '0;
			rx_string <= '0;
			rx_done   <= 1'b0;
			rx_error  <= 1'b0;
		end else begin
			rx_done  <= 1'b0;
			rx_error <= 1'b0;
			if (timeout || overflow) begin
				state    <= asm_hunt;
				rx_error <= 1'b1;
			end else if (byte_vld) begin
				case (state)
					asm_hunt: begin
						if (is_mark)
							state <= asm_mark1;
					end
					asm_mark1: begin
						fill_len <= '0;
						state    <= is_mark ? asm_body : asm_hunt;
					end
					asm_body: begin
						if (is_mark)
							state <= asm_pend_mark;
						else
							fill_len <= fill_len + 1'b1;
					end
					asm_pend_mark: begin
						if (is_mark) begin
							// closing "&&", hand the frame out
							state          <= asm_hunt;
							rx_done        <= 1'b1;
							rx_string.len  <= fill_len;
							rx_string.data <= fill_data;
						end else begin
							state    <= asm_body;
							fill_len <= fill_len + 2'd2;
						end
					end
					default: state <= asm_hunt;
				endcase
			end
		end
	end

	// content buffer, cleared at frame start so unused bytes read as zero
	always_ff @(posedge sys_clk) begin
		if (frame_open) begin
			fill_data <= '0;
		end else if (store_one && !overflow) begin
			fill_data[fill_len*8 +: 8] <= byte_data;
		end else if (store_two && !overflow) begin
			fill_data[fill_len*8 +: 8]     <= frame_mark;
			fill_data[(fill_len+1)*8 +: 8] <= byte_data;
		end
	end

endmodule

`default_nettype wire

// File: design/frame_sender.sv
/*
 * framed string sender
 * sends "&&", len content bytes and "&&" through the byte transmitter,
 * one byte per byte_req, with busy and done towards the user
 */
`default_nettype none

module frame_sender (
	input  wire                         sys_clk,
	input  wire                         sys_rst_n,
	input  wire uart_pkg::uart_string_t tx_string,
	input  wire                         tx_req,
	input  wire                         byte_done,
	output logic                        tx_busy,
	output logic                        tx_done,
	output logic [7:0]                  byte_data,
	output logic                        byte_req
);
	import uart_pkg::*;

	send_state_t      state;
	uart_string_t     str;
	logic [len_w-1:0] idx;

	assign tx_busy = (state != send_idle);

	// the state names the byte that is on the line
	assign byte_data = (state == send_body) ? str.data[idx*8 +: 8] : frame_mark;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= send_idle;
			idx      <= '0;
			byte_req <= 1'b0;
			tx_done  <= 1'b0;
		end else begin
			byte_req <= 1'b0;
			tx_done  <= 1'b0;
			case (state)
				send_idle: begin
					if (tx_req) begin
						state    <= send_head1;
						byte_req <= 1'b1;
					end
				end
				send_head1: begin
					if (byte_done) begin
						state    <= send_head2;
						byte_req <= 1'b1;
					end
				end
				send_head2: begin
					if (byte_done) begin
						byte_req <= 1'b1;
						idx      <= '0;
						// empty string goes straight to the closing marks
						state    <= (str.len == '0) ? send_tail1 : send_body;
					end
				end
				send_body: begin
					if (byte_done) begin
						byte_req <= 1'b1;
						if (idx == str.len - 1'b1)
							state <= send_tail1;
						else
							idx <= idx + 1'b1;
					end
				end
				send_tail1: begin
					if (byte_done) begin
						state    <= send_tail2;
						byte_req <= 1'b1;
					end
				end
				send_tail2: begin
					if (byte_done) begin
						state   <= send_idle;
						tx_done <= 1'b1;
					end
				end
				default: state <= send_idle;
			endcase
		end
	end

	// capture on an accepted request, length clipped to the buffer size
	always_ff @(posedge sys_clk) begin
		if (state == send_idle && tx_req) begin
			str.data <= tx_string.data;
			str.len  <= (tx_string.len > len_w'(str_max_bytes)) ?
				len_w'(str_max_bytes) : tx_string.len;
		end
	end

endmodule

`default_nettype wire

// File: design/uart_rx.sv
/*
 * uart byte receiver
 * two-flop input sync, start bit rechecked at mid-bit,
 * data sampled at mid-bit, byte_vld only on a good stop bit
 */
`default_nettype none

module uart_rx #(
	parameter int clk_freq  = 50_000_000,
	parameter int baud_rate = 115_200
) (
	input  wire        sys_clk,
	input  wire        sys_rst_n,
	input  wire        rx,
	output logic [7:0] byte_data,
	output logic       byte_vld
);
	import uart_pkg::*;

	localparam int clks_per_bit = clk_freq / baud_rate;
	localparam int half_bit     = clks_per_bit / 2;
	localparam int cnt_w        = $clog2(clks_per_bit + 1);

	rx_state_t        state;
	logic [cnt_w-1:0] baud_cnt;
	logic [2:0]       bit_cnt;
	logic             rx_meta;
	logic             rx_sync;
	logic             rx_prev;
	logic             fall;
	logic             sample;

	// line idles high, so the sync chain resets to 1
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	assign fall = rx_prev & ~rx_sync;

	// half a bit into the start bit, then one full bit per step
	assign sample = (state == rx_start) ? (baud_cnt == cnt_w'(half_bit - 1)) :
		(baud_cnt == cnt_w'(clks_per_bit - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			baud_cnt <= '0;
		else if (state == rx_idle || sample)
			baud_cnt <= '0;
		else
			baud_cnt <= baud_cnt + 1'b1;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= rx_idle;
			bit_cnt  <= '0;
			byte_vld <= 1'b0;
		end else begin
			byte_vld <= 1'b0;
			case (state)
				rx_idle: begin
					if (fall)
						state <= rx_start;
				end
				rx_start: begin
					if (sample) begin
						// short glitch, not a real start bit
						state   <= rx_sync ? rx_idle : rx_data;
						bit_cnt <= '0;
					end
				end
				rx_data: begin
					if (sample) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= rx_stop;
					end
				end
				rx_stop: begin
					if (sample) begin
						state    <= rx_idle;
						byte_vld <= rx_sync;
					end
				end
				default: state <= rx_idle;
			endcase
		end
	end

	// lsb arrives first, shift in from the top
	always_ff @(posedge sys_clk) begin
		if (state == rx_data && sample)
			byte_data <= {rx_sync, byte_data[7:1]};
	end

endmodule

`default_nettype wire

// File: design/uart_tx.sv
/*
 * uart byte transmitter
 * start bit, 8 data bits lsb first, one stop bit
 * byte_done pulses once the stop bit has gone out
 */
`default_nettype none

module uart_tx #(
	parameter int clk_freq  = 50_000_000,
	parameter int baud_rate = 115_200
) (
	input  wire        sys_clk,
	input  wire        sys_rst_n,
	input  wire  [7:0] byte_data,
	input  wire        byte_req,
	output logic       tx,
	output logic       byte_done
);
	import uart_pkg::*;

	localparam int clks_per_bit = clk_freq / baud_rate;
	localparam int cnt_w        = $clog2(clks_per_bit + 1);

	tx_state_t        state;
	logic [cnt_w-1:0] baud_cnt;
	logic [2:0]       bit_cnt;
	logic [7:0]       shift_reg;
	logic             bit_end;

	// last clock of the current bit period
	assign bit_end = (baud_cnt == cnt_w'(clks_per_bit - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			baud_cnt <= '0;
		else if (state == tx_idle || bit_end)
			baud_cnt <= '0;
		else
			baud_cnt <= baud_cnt + 1'b1;
	end

	// line level is registered so the pin never glitches
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= tx_idle;
			bit_cnt   <= '0;
			tx        <= 1'b1;
			byte_done <= 1'b0;
		end else begin
			byte_done <= 1'b0;
			case (state)
				tx_idle: begin
					if (byte_req) begin
						state <= tx_start;
						tx    <= 1'b0;
					end
				end
				tx_start: begin
					if (bit_end) begin
						state   <= tx_data;
						bit_cnt <= '0;
						tx      <= shift_reg[0];
					end
				end
				tx_data: begin
					if (bit_end) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7) begin
							state <= tx_stop;
							tx    <= 1'b1;
						end else begin
							// shifter moves on the same edge
							tx <= shift_reg[1];
						end
					end
				end
				tx_stop: begin
					if (bit_end) begin
						state     <= tx_idle;
						byte_done <= 1'b1;
					end
				end
				default: state <= tx_idle;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == tx_idle && byte_req)
			shift_reg <= byte_data;
		else if (state == tx_data && bit_end)
			shift_reg <= {1'b0, shift_reg[7:1]};
	end

endmodule

`default_nettype wire

// File: design/uart_pkg.sv
/*
 * uart string transceiver shared definitions
 * string buffer size, framing byte, string struct and FSM state types
 */
`default_nettype none

package uart_pkg;

	// capacity of one string buffer in bytes
	localparam int str_max_bytes = 32;

	// byte count 0..str_max_bytes
	localparam int len_w = $clog2(str_max_bytes + 1);

	// a frame opens and closes with two of these
	localparam logic [7:0] frame_mark = 8'h26;

	// byte 0 goes first on the line and sits in the lowest byte of data
	typedef struct packed {
		logic [len_w-1:0]           len;
		logic [str_max_bytes*8-1:0] data;
	} uart_string_t;

	typedef enum logic [1:0] {
		tx_idle,
		tx_start,
		tx_data,
		tx_stop
	} tx_state_t;

	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop
	} rx_state_t;

	typedef enum logic [2:0] {
		send_idle,
		send_head1,
		send_head2,
		send_body,
		send_tail1,
		send_tail2
	} send_state_t;

	typedef enum logic [1:0] {
		asm_hunt,
		asm_mark1,
		asm_body,
		asm_pend_mark
	} asm_state_t;

endpackage

`default_nettype wire
